// ==== rtl/pov_settings.svh ====
/* Build-time settings of the SPI command path
   FIFO depth, pin synchronizer length, MISO status width,
   payload byte counts for each opcode */
`ifndef POV_SETTINGS_SVH
`define POV_SETTINGS_SVH

// Byte entries in the command FIFO, must be a power of two
`define POV_FIFO_DEPTH 16

// Flip-flops per SPI pin synchronizer, two or more
`define POV_SYNC_STAGES 2

// Status word on MISO, rotation in the upper half, speed in the lower
`define POV_STATUS_BITS 32

// Payload bytes expected after each opcode
`define POV_CONF_BYTES 6
`define POV_DISPLAY_BYTES 1
`define POV_MUX_BYTES 1

`endif

// ==== rtl/pov_pkg.sv ====
/* Shared types of the SPI command path
   Opcodes, column driver configuration, configuration payload union,
   command FIFO entry */
`include "pov_settings.svh"

package pov_pkg;

   // Command codes, first byte of every SPI frame
   typedef enum logic [7:0] {
      OP_CONFIG      = 8'h01,
      OP_DISPLAY     = 8'h02,
      OP_MUX_SET     = 8'h03,
      OP_MUX_RELEASE = 8'h04
   } opcode_e;

   // Column driver configuration, MSB first as sent by the host
   typedef struct packed {
      logic [23:0] brightness;
      logic [7:0]  blank_cycles;
      logic [7:0]  sclk_div;
      logic [7:0]  gclk_div;
   } driver_conf_t;

   // Configuration payload
   // Written byte by byte, read back as driver fields
   // bytes[5] holds the first payload byte on the wire
   typedef union packed {
      driver_conf_t                     fields;
      logic [`POV_CONF_BYTES-1:0][7:0] bytes;
   } conf_payload_u;

   // One received byte
   // first marks the opcode position, i.e. first byte after CS falls
   typedef struct packed {
      logic       first;
      logic [7:0] data;
   } fifo_entry_t;

endpackage

// ==== rtl/spi_byte_if.sv ====
/* Byte link from the SPI slave to the command FIFO
   Producer and buffer modports */
`timescale 1ns/1ps

interface spi_byte_if;

   // Assembled byte and its frame-start flag
   logic [7:0] data;
   logic       first;
   // One clk pulse per byte, no acceptance path back
   logic       strobe;
   // Sticky FIFO overflow, driven by the buffer side
   logic       overflow;

   modport producer (
      output data,
      output first,
      output strobe,
      input  overflow
   );

   modport buffer (
      input  data,
      input  first,
      input  strobe,
      output overflow
   );

endinterface

// ==== rtl/spi_iff.sv ====
/* SPI mode 0 slave running on the system clock
   Pin synchronizers and SCLK edge detection
   MOSI byte assembly with first-byte marking
   MISO shifter for the rotation and speed status word */
`timescale 1ns/1ps
`include "pov_settings.svh"

module spi_iff (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          som_cs,
   input  logic                          som_sclk,
   input  logic                          som_mosi,
   input  logic [`POV_STATUS_BITS/2-1:0] rotation_data,
   input  logic [`POV_STATUS_BITS/2-1:0] speed_data,
   output logic                          som_miso,
   spi_byte_if.producer                  bytes
);

   localparam int STAGES = `POV_SYNC_STAGES;
   localparam int SW     = `POV_STATUS_BITS;

   // Each stage holds {cs, sclk, mosi}
   logic [STAGES-1:0][2:0] sync_q;
   logic                   cs_s;
   logic                   sclk_s;
   logic                   mosi_s;
   logic                   cs_d;
   logic                   sclk_d;
   logic                   cs_fall;
   logic                   sclk_rise;
   logic                   sclk_fall;
   logic [2:0]             bit_cnt;
   logic [6:0]             shift_q;
   logic                   first_pend;
   logic [SW-1:0]          status_q;

   // Pin synchronizers
   // Idle pattern is CS high, SCLK low, so no false edge leaves reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= {STAGES{3'b100}};
      end else begin
         sync_q <= {sync_q[STAGES-2:0], {som_cs, som_sclk, som_mosi}};
      end
   end

   assign {cs_s, sclk_s, mosi_s} = sync_q[STAGES-1];

   // Previous synchronized levels for edge detection
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cs_d   <= 1'b1;
         sclk_d <= 1'b0;
      end else begin
         cs_d   <= cs_s;
         sclk_d <= sclk_s;
      end
   end

   assign cs_fall   = cs_d & ~cs_s;
   // SCLK edges only count inside a selected frame
   assign sclk_rise = ~cs_s & sclk_s & ~sclk_d;
   assign sclk_fall = ~cs_s & ~sclk_s & sclk_d;

   // Bit counter and byte strobe
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bit_cnt      <= '0;
         first_pend   <= 1'b0;
         bytes.strobe <= 1'b0;
         bytes.first  <= 1'b0;
      end else begin
         bytes.strobe <= 1'b0;
         if (cs_s) begin
            // Deselect drops any partial byte
            bit_cnt <= '0;
         end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            // Eighth edge, strobe shows up one cycle later
            if (bit_cnt == 3'd7) begin
               bytes.strobe <= 1'b1;
               bytes.first  <= first_pend;
               first_pend   <= 1'b0;
            end
         end
         // Next complete byte is the opcode
         if (cs_fall) begin
            first_pend <= 1'b1;
         end
      end
   end

   // MOSI data path, MSB first
   always_ff @(posedge clk) begin
      if (sclk_rise) begin
         shift_q <= {shift_q[5:0], mosi_s};
         if (bit_cnt == 3'd7) begin
            bytes.data <= {shift_q, mosi_s};
         end
      end
   end

   // Status word
   // Loaded on CS fall so its MSB leads before the first rising edge,
   // shifted on falling edges, zeros fill in behind
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         status_q <= '0;
      end else if (cs_fall) begin
         status_q <= {rotation_data, speed_data};
      end else if (cs_s) begin
         status_q <= '0;
      end else if (sclk_fall) begin
         status_q <= {status_q[SW-2:0], 1'b0};
      end
   end

   assign som_miso = status_q[SW-1];

endmodule

// ==== rtl/cmd_fifo.sv ====
/* Command byte FIFO between the SPI slave and the decoder
   Circular buffer with occupancy count, sticky overflow flag */
`timescale 1ns/1ps
`include "pov_settings.svh"

module cmd_fifo (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 pop,
   spi_byte_if.buffer           bytes,
   output logic                 empty,
   output pov_pkg::fifo_entry_t entry
);

   import pov_pkg::*;

   localparam int DEPTH = `POV_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   fifo_entry_t   mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;
   logic          do_push;
   logic          do_pop;

   assign empty  = (count == '0);
   // Depth is a power of two, so the count MSB alone means full
   assign full   = count[AW];
   assign do_pop = pop & ~empty;
   // A pop in the same cycle frees the slot for a push on full
   assign do_push = bytes.strobe & (~full | do_pop);

   // Head entry, read combinationally
   assign entry = mem[rd_ptr];

   // Storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= '{first: bytes.first, data: bytes.data};
      end
   end

   // Pointers, count and overflow
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         count          <= '0;
         bytes.overflow <= 1'b0;
      end else begin
         // Pointers wrap naturally at the power-of-two depth
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Lost byte, flag holds until reset
         if (bytes.strobe && !do_push) begin
            bytes.overflow <= 1'b1;
         end
      end
   end

endmodule

// ==== rtl/spi_decoder.sv ====
/* Host command decoder
   Opcode and payload FSM fed from the command FIFO
   Driver configuration assembly, RGB enable, row mux override */
`timescale 1ns/1ps
`include "pov_settings.svh"

module spi_decoder (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  empty,
   input  pov_pkg::fifo_entry_t  entry,
   input  logic [7:0]            mux_out,
   output logic                  pop,
   output pov_pkg::driver_conf_t driver_conf,
   output logic                  new_config,
   output logic                  rgb_enable,
   output logic                  manage_mux,
   output logic [7:0]            fpga_mul
);

   import pov_pkg::*;

   // Waiting for an opcode, or counting payload bytes
   typedef enum logic {
      ST_IDLE,
      ST_PAYLOAD
   } state_e;

   localparam int CW = $clog2(`POV_CONF_BYTES + 1);

   state_e        state;
   opcode_e       op_q;
   logic [CW-1:0] remaining;
   conf_payload_u conf_q;
   conf_payload_u conf_next;
   logic [7:0]    mux_force_q;
   logic [7:0]    rx;
   logic          payload_byte;
   logic          last;

   // Drain one byte per cycle whenever anything is queued
   assign pop = ~empty;
   assign rx  = entry.data;

   // Payload byte of a command still in progress
   assign payload_byte = pop & ~entry.first & (state == ST_PAYLOAD);
   assign last         = (remaining == CW'(1));

   // Byte view shifts in, oldest byte ends up most significant
   always_comb begin
      conf_next.bytes = {conf_q.bytes[`POV_CONF_BYTES-2:0], rx};
   end

   // Payload holding registers
   always_ff @(posedge clk) begin
      if (payload_byte && op_q == OP_CONFIG) begin
         conf_q <= conf_next;
      end
      if (payload_byte && op_q == OP_MUX_SET) begin
         mux_force_q <= rx;
      end
   end

   // Command FSM and output registers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= ST_IDLE;
         op_q        <= OP_MUX_RELEASE;
         remaining   <= '0;
         driver_conf <= '0;
         new_config  <= 1'b0;
         rgb_enable  <= 1'b0;
         manage_mux  <= 1'b0;
      end else begin
         new_config <= 1'b0;
         if (pop && entry.first) begin
            // Frame start, anything unfinished is dropped here
            state <= ST_PAYLOAD;
            case (rx)
               OP_CONFIG: begin
                  op_q      <= OP_CONFIG;
                  remaining <= CW'(`POV_CONF_BYTES);
               end
               OP_DISPLAY: begin
                  op_q      <= OP_DISPLAY;
                  remaining <= CW'(`POV_DISPLAY_BYTES);
               end
               OP_MUX_SET: begin
                  op_q      <= OP_MUX_SET;
                  remaining <= CW'(`POV_MUX_BYTES);
               end
               OP_MUX_RELEASE: begin
                  // No payload, takes effect right away
                  op_q       <= OP_MUX_RELEASE;
                  manage_mux <= 1'b0;
                  state      <= ST_IDLE;
               end
               // Unknown code, rest of the frame falls through idle
               default: state <= ST_IDLE;
            endcase
         end else if (payload_byte) begin
            remaining <= remaining - 1'b1;
            if (last) begin
               state <= ST_IDLE;
               case (op_q)
                  OP_CONFIG: begin
                     driver_conf <= conf_next.fields;
                     new_config  <= 1'b1;
                  end
                  OP_DISPLAY: rgb_enable <= rx[0];
                  OP_MUX_SET: manage_mux <= 1'b1;
                  default:    manage_mux <= manage_mux;
               endcase
            end
         end
      end
   end

   // Row mux select, forced value overrides the driver controller
   assign fpga_mul = manage_mux ? mux_force_q : mux_out;

endmodule

// ==== rtl/pov_spi_top.sv ====
/* Top of the host command path
   SPI slave, command FIFO and decoder on plain ports */
`timescale 1ns/1ps
`include "pov_settings.svh"

module pov_spi_top (
   input  logic                          clk,
   input  logic                          arst_n,
   // SPI from the SBC
   input  logic                          som_cs,
   input  logic                          som_sclk,
   input  logic                          som_mosi,
   output logic                          som_miso,
   // Status returned on MISO
   input  logic [`POV_STATUS_BITS/2-1:0] rotation_data,
   input  logic [`POV_STATUS_BITS/2-1:0] speed_data,
   // Mux value from the driver controller
   input  logic [7:0]                    mux_out,
   // Column driver configuration
   output logic [47:0]                   driver_conf,
   output logic                          new_config,
   // Display and row mux control
   output logic                          rgb_enable,
   output logic                          manage_mux,
   output logic [7:0]                    fpga_mul,
   // Lost command byte
   output logic                          overflow
);

   import pov_pkg::*;

   fifo_entry_t  entry;
   driver_conf_t conf;
   logic         pop;
   logic         empty;

   // Byte link between slave and FIFO
   spi_byte_if bytes_if ();

   spi_iff spi_iff (
      .clk           (clk),
      .arst_n        (arst_n),
      .som_cs        (som_cs),
      .som_sclk      (som_sclk),
      .som_mosi      (som_mosi),
      .rotation_data (rotation_data),
      .speed_data    (speed_data),
      .som_miso      (som_miso),
      .bytes         (bytes_if.producer)
   );

   cmd_fifo cmd_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .pop    (pop),
      .bytes  (bytes_if.buffer),
      .empty  (empty),
      .entry  (entry)
   );

   spi_decoder spi_decoder (
      .clk         (clk),
      .arst_n      (arst_n),
      .empty       (empty),
      .entry       (entry),
      .mux_out     (mux_out),
      .pop         (pop),
      .driver_conf (conf),
      .new_config  (new_config),
      .rgb_enable  (rgb_enable),
      .manage_mux  (manage_mux),
      .fpga_mul    (fpga_mul)
   );

   // Configuration leaves as a flat vector
   assign driver_conf = conf;
   assign overflow    = bytes_if.overflow;

endmodule

// ==== test/tb_clock.sv ====
/* Testbench clock and reset source
   100 ns clock, reset held low for 16 cycles */
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

// ==== test/pov_spi_assertions.sv ====
/* Concurrent checks on the command decoder
   Config strobe width, row mux select, reset values */
`timescale 1ns/1ps

module pov_spi_assertions (
   input logic        clk,
   input logic        arst_n,
   input logic        pop,
   input logic [7:0]  rx,
   input logic        new_config,
   input logic        rgb_enable,
   input logic        manage_mux,
   input logic [47:0] driver_conf,
   input logic [7:0]  mux_out,
   input logic [7:0]  fpga_mul
);

   // Failed checks so far, watched from the testbench top
   int unsigned fail_count = 0;

   // Config strobe is a single-cycle pulse
   new_config_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      new_config |=> !new_config)
      else begin
         $error("new_config held for more than one cycle");
         fail_count = fail_count + 1;
      end

   // Forced row select takes the MUX_SET payload byte just popped
   mux_forced_load: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(manage_mux) |-> (fpga_mul == $past(rx)))
      else begin
         $error("fpga_mul does not take the forced payload byte");
         fail_count = fail_count + 1;
      end

   // Forced value holds against mux_out until another byte is popped
   mux_forced_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (manage_mux && $past(manage_mux) && !$past(pop)) |-> $stable(fpga_mul))
      else begin
         $error("fpga_mul does not hold the forced value");
         fail_count = fail_count + 1;
      end

   // Driver controller value otherwise
   mux_released: assert property (@(posedge clk) disable iff (!arst_n)
      !manage_mux |-> (fpga_mul == mux_out))
      else begin
         $error("fpga_mul does not follow mux_out");
         fail_count = fail_count + 1;
      end

   // Everything quiet while reset is held
   reset_values: assert property (@(posedge clk)
      !arst_n |-> (!pop && !new_config && !rgb_enable && !manage_mux
                   && driver_conf == '0))
      else begin
         $error("decoder outputs not cleared during reset");
         fail_count = fail_count + 1;
      end

endmodule

// ==== test/tb_pov_spi.sv ====
/* Testbench for the SPI command path
   Stimulus file reader, SPI mode 0 frame driver with MISO capture,
   value compare, cycle limit and final verdict */
`timescale 1ns/1ps

module tb_pov_spi;

   // Words per stimulus line, see the column note in the data file
   localparam int WORDS     = 17;
   localparam int MAX_LINES = 24;

   logic        clk;
   logic        arst_n;
   logic        som_cs;
   logic        som_sclk;
   logic        som_mosi;
   logic        som_miso;
   logic [15:0] rotation_data;
   logic [15:0] speed_data;
   logic [7:0]  mux_out;
   logic [47:0] driver_conf;
   logic        new_config;
   logic        rgb_enable;
   logic        manage_mux;
   logic [7:0]  fpga_mul;
   logic        overflow;

   logic [47:0] stim [WORDS*MAX_LINES];
   integer      seed;
   integer      cycles;
   integer      limit;
   integer      conf_pulses;

   tb_clock clock_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   pov_spi_top UUT (
      .clk           (clk),
      .arst_n        (arst_n),
      .som_cs        (som_cs),
      .som_sclk      (som_sclk),
      .som_mosi      (som_mosi),
      .som_miso      (som_miso),
      .rotation_data (rotation_data),
      .speed_data    (speed_data),
      .mux_out       (mux_out),
      .driver_conf   (driver_conf),
      .new_config    (new_config),
      .rgb_enable    (rgb_enable),
      .manage_mux    (manage_mux),
      .fpga_mul      (fpga_mul),
      .overflow      (overflow)
   );

   bind spi_decoder pov_spi_assertions decoder_checks (
      .clk         (clk),
      .arst_n      (arst_n),
      .pop         (pop),
      .rx          (rx),
      .new_config  (new_config),
      .rgb_enable  (rgb_enable),
      .manage_mux  (manage_mux),
      .driver_conf (driver_conf),
      .mux_out     (mux_out),
      .fpga_mul    (fpga_mul)
   );

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic compare(input string name, input logic [47:0] expected,
                          input logic [47:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("ERR %0t ns %s expected %h actual %h",
                             $time, name, expected, actual));
      end
   endtask

   // One frame, four clk cycles per SCLK half period
   // MISO is sampled as SCLK rises, status MSB first then zeros
   task automatic run_frame(input int base, input int n);
      logic [31:0] status;
      int          k;
      status = {rotation_data, speed_data};
      k      = 0;
      som_cs = 1'b0;
      for (int b = 0; b < n; b++) begin
         for (int i = 7; i >= 0; i--) begin
            som_sclk = 1'b0;
            som_mosi = stim[base + b][i];
            repeat (4) @(negedge clk);
            som_sclk = 1'b1;
            compare("som_miso", (k < 32) ? status[31 - k] : 1'b0, som_miso);
            k++;
            repeat (4) @(negedge clk);
         end
      end
      som_sclk = 1'b0;
      repeat (4) @(negedge clk);
      som_cs = 1'b1;
   endtask

   // Cycle limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit != 0 && cycles > limit) begin
         abort_run($sformatf("Timeout, run went past %0d clock cycles", limit));
      end
   end

   // Decoder checker, a failed assertion ends the run
   always @(negedge clk) begin
      if (UUT.spi_decoder.decoder_checks.fail_count != 0) begin
         abort_run("An assertion on the command decoder failed");
      end
   end

   // Config strobes, counted where the level is stable
   always @(negedge clk) begin
      if (new_config) begin
         conf_pulses = conf_pulses + 1;
      end
   end

   initial begin : main
      int nlines;
      int total_bytes;
      int base;
      int n;
      int gap;
      seed          = 32'h45ef691e;
      som_cs        = 1'b1;
      som_sclk      = 1'b0;
      som_mosi      = 1'b0;
      rotation_data = '0;
      speed_data    = '0;
      mux_out       = '0;
      cycles        = 0;
      limit         = 0;
      conf_pulses   = 0;
      $readmemh("test/pov_spi_stim.txt", stim);
      // Lines run up to a zero byte count or the end of the data
      nlines      = 0;
      total_bytes = 0;
      while (nlines < MAX_LINES && !$isunknown(stim[nlines*WORDS])
             && stim[nlines*WORDS] != 0) begin
         total_bytes += stim[nlines*WORDS];
         nlines++;
      end
      if (nlines == 0) begin
         abort_run("Stimulus file holds no frames");
      end
      limit = total_bytes*64 + nlines*100 + 200;
      @(posedge arst_n);
      repeat (8) @(negedge clk);
      for (int line = 0; line < nlines; line++) begin
         base          = line*WORDS;
         n             = stim[base];
         rotation_data = stim[base + 9];
         speed_data    = stim[base + 10];
         mux_out       = stim[base + 11];
         conf_pulses   = 0;
         run_frame(base + 1, n);
         // Minimum gap or a random one of 8 to 40 cycles
         gap = (stim[base + 16] != 0) ? 8 : 8 + ({$random(seed)} % 33);
         repeat (gap) @(negedge clk);
         // A complete config frame gives exactly one strobe
         compare("new_config pulses",
                 (stim[base + 1] == 48'h01 && n >= 7) ? 1 : 0, conf_pulses);
         compare("driver_conf", stim[base + 12], driver_conf);
         compare("rgb_enable", stim[base + 13], rgb_enable);
         compare("manage_mux", stim[base + 14], manage_mux);
         compare("fpga_mul", stim[base + 15], fpga_mul);
         compare("overflow", 48'h0, overflow);
      end
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/pov_pkg.sv
rtl/spi_byte_if.sv
rtl/spi_iff.sv
rtl/cmd_fifo.sv
rtl/spi_decoder.sv
rtl/pov_spi_top.sv
test/tb_clock.sv
test/pov_spi_assertions.sv
test/tb_pov_spi.sv

// ==== test/pov_spi_stim.txt ====
// count b0 b1 b2 b3 b4 b5 b6 b7 rotation speed mux_out
// exp_driver_conf exp_rgb_enable exp_manage_mux exp_fpga_mul min_gap
7 01 12 34 56 9A 0B 03 00 A5C3 1F80 11 1234569A0B03 0 0 11 0
2 02 01 00 00 00 00 00 00 0F0F F0F0 22 1234569A0B03 1 0 22 0
2 03 5A 00 00 00 00 00 00 8001 7FFE 33 1234569A0B03 1 1 5A 0
3 7E 01 02 00 00 00 00 00 1234 5678 44 1234569A0B03 1 1 5A 0
4 01 FF EE DD 00 00 00 00 DEAD BEEF 55 1234569A0B03 1 1 5A 0
1 02 00 00 00 00 00 00 00 CAFE 0001 66 1234569A0B03 1 1 5A 0
1 04 00 00 00 00 00 00 00 0000 FFFF 77 1234569A0B03 1 0 77 0
7 01 A1 B2 C3 D4 E5 F6 00 1357 2468 78 A1B2C3D4E5F6 1 0 78 1
2 02 FE 00 00 00 00 00 00 9BDF 0246 79 A1B2C3D4E5F6 0 0 79 1
2 03 C0 00 00 00 00 00 00 4321 8765 7A A1B2C3D4E5F6 0 1 C0 1
7 01 00 00 01 40 20 08 00 FFFF 0000 7B 000001402008 0 1 C0 1
1 04 00 00 00 00 00 00 00 5555 AAAA 7C 000001402008 0 0 7C 1
0
